// ==== common/cpu_macros.svh ====
// CPU constants
// Widths, memory depths, register count and RV32I opcodes
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define XLEN        32              // Data and address width
`define IMEM_DEPTH  128             // Instruction memory words
`define DMEM_DEPTH  128             // Data memory words
`define NREGS       32              // Architectural registers

`define NOP_INSTR   32'h0000_0013   // ADDI x0, x0, 0

// Major opcodes of the supported subset
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`endif

// ==== common/cpu_pkg.sv ====
// CPU package
// Control word, stage payloads, retire trace and program-write port types
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]           word_t;
    typedef logic [$clog2(`NREGS)-1:0]  reg_idx_t;

    // ALU operations, add is zero so a bubble does an add
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    // All-zero value is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;   // Operand B from immediate
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    mem_to_reg;    // Writeback from load data
        logic    branch;        // BEQ
        logic    jump;          // JAL / JALR
        logic    jump_reg;      // JALR, base is rs1
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;   // Or link value on jumps
        word_t    store_data;
        word_t    target;
        logic     take;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    wb_data;
    } mem_wb_t;

    // Retire trace seen at the top
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_trace_t;

    typedef struct packed {
        logic                           we;
        logic [$clog2(`IMEM_DEPTH)-1:0] addr;   // Word address
        word_t                          data;
    } imem_write_t;

endpackage

// ==== rtl/pipe_reg.sv ====
// Pipeline stage register
// One payload type per boundary, reset and flush load a bubble
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = cpu_pkg::ctrl_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,     // Kill the younger instruction
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= payload_t'('0);  // Bubble
        end else begin
            q <= d;
        end
    end

    // A flushed slot must leave as a bubble, whatever arrived at d
    a_flush_bubble: assert property (@(posedge clk) disable iff (reset)
        flush |=> q == payload_t'('0))
        else $error("pipe_reg not a bubble after flush");

endmodule

// ==== rtl/fetch/fetch_stage.sv ====
// Fetch stage
// PC, next-PC select, instruction memory with its program-write port
// NOP injection on redirect and while the core is held
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  cpu_pkg::imem_write_t prog,
    input  logic                 redirect,
    input  cpu_pkg::word_t       redirect_pc,
    output cpu_pkg::word_t       instr,
    output cpu_pkg::word_t       pc
);

    localparam int aw = $clog2(`IMEM_DEPTH);

    cpu_pkg::word_t imem [`IMEM_DEPTH];
    cpu_pkg::word_t pc_next;
    logic           imem_we;

    // ========================================
    // Program counter
    // ========================================
    assign pc_next = redirect ? redirect_pc : pc + cpu_pkg::word_t'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (enable) begin     // Held while programming
            pc <= pc_next;
        end
    end

    // ========================================
    // Instruction memory
    // ========================================
    assign imem_we = prog.we && !enable;   // Only while halted

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[prog.addr] <= prog.data;
        end
    end

    // Bubble while redirecting, or while held so the pipe drains
    assign instr = (redirect || !enable) ? `NOP_INSTR : imem[pc[aw+1:2]];

    a_no_write_running: assert property (@(posedge clk)
        enable && prog.we |=> imem[$past(prog.addr)] == $past(imem[prog.addr]))
        else $error("imem written while enable high");

endmodule

// ==== rtl/decode/decoder.sv ====
// Instruction decoder
// Control word and immediate for the reduced RV32I subset
// Unknown encodings decode to a bubble
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decoder (
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::ctrl_t    ctrl,
    output cpu_pkg::word_t    imm,
    output cpu_pkg::reg_idx_t rs1,
    output cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::reg_idx_t rd
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             is_sub;
    logic             f3_ok;
    cpu_pkg::alu_op_e f3_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign is_sub = (opcode == `OP_RTYPE) && instr[30];  // funct7 bit 5, R-type only

    // funct3 to ALU op, shared by R and I forms
    always_comb begin
        f3_ok = 1'b1;
        f3_op = cpu_pkg::alu_add;
        case (funct3)
            3'b000:  f3_op = is_sub ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b111:  f3_op = cpu_pkg::alu_and;
            3'b110:  f3_op = cpu_pkg::alu_or;
            3'b100:  f3_op = cpu_pkg::alu_xor;
            3'b010:  f3_op = cpu_pkg::alu_slt;
            default: f3_ok = 1'b0;              // Shifts and SLTU not supported
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            `OP_RTYPE: begin
                ctrl.reg_write = f3_ok;
                ctrl.alu_op    = f3_op;
            end
            `OP_ITYPE: begin
                ctrl.reg_write   = f3_ok;
                ctrl.alu_op      = f3_op;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};                // I
            end
            `OP_LOAD: begin                                           // LW only
                ctrl.reg_write   = (funct3 == 3'b010);
                ctrl.mem_read    = (funct3 == 3'b010);
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            `OP_STORE: begin                                          // SW only
                ctrl.mem_write   = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // S
            end
            `OP_BRANCH: begin                                         // BEQ only
                ctrl.branch = (funct3 == 3'b000);
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};                            // B
            end
            `OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};                           // J
            end
            `OP_JALR: begin                                           // rs1 + imm via ALU add
                ctrl.jump        = 1'b1;
                ctrl.jump_reg    = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            default: ctrl = '0;
        endcase
        // Writes to x0 are dropped here, so they never forward or retire
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
    end

endmodule

// ==== rtl/decode/reg_file.sv ====
// Register file
// 32 x 32, x0 reads zero, same-cycle write passes through to the read ports
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t wr,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2
);

    cpu_pkg::word_t regs [`NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr != '0) begin   // x0 never written
            regs[wr] <= wdata;
        end
    end

    // WB write visible to the instruction in decode this cycle
    assign rdata1 = (rs1 == '0) ? '0 : (we && wr == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (we && wr == rs2) ? wdata : regs[rs2];

    a_x0_zero: assert property (@(posedge clk) regs[0] == '0)
        else $error("stored x0 is nonzero");

endmodule

// ==== rtl/execute/execute_stage.sv ====
// Execute stage
// Forwarding from EX/MEM and MEM/WB, operand muxes, ALU,
// BEQ compare and jump target / link computation
`timescale 1ns/1ps

module execute_stage (
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::word_t    fwd_mem_data,   // EX/MEM result
    input  cpu_pkg::reg_idx_t fwd_mem_rd,
    input  logic              fwd_mem_we,
    input  cpu_pkg::word_t    fwd_wb_data,    // MEM/WB writeback value
    input  cpu_pkg::reg_idx_t fwd_wb_rd,
    input  logic              fwd_wb_we,
    output cpu_pkg::ex_mem_t  ex_mem
);

    cpu_pkg::word_t op_a;      // Forwarded rs1
    cpu_pkg::word_t rs2_fwd;   // Forwarded rs2, also store data
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t link_pc;
    cpu_pkg::word_t target;

    // Newest producer wins, x0 never forwarded
    function automatic cpu_pkg::word_t forward(input cpu_pkg::reg_idx_t rs,
                                               input cpu_pkg::word_t rf_data);
        if (rs != '0 && fwd_mem_we && fwd_mem_rd == rs) begin
            return fwd_mem_data;
        end
        if (rs != '0 && fwd_wb_we && fwd_wb_rd == rs) begin
            return fwd_wb_data;
        end
        return rf_data;
    endfunction

    // ========================================
    // Operands
    // ========================================
    always_comb begin
        op_a    = forward(id_ex.rs1, id_ex.rs1_data);
        rs2_fwd = forward(id_ex.rs2, id_ex.rs2_data);
    end

    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_fwd;

    // ========================================
    // ALU
    // ========================================
    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::alu_add: alu_out = op_a + op_b;
            cpu_pkg::alu_sub: alu_out = op_a - op_b;
            cpu_pkg::alu_and: alu_out = op_a & op_b;
            cpu_pkg::alu_or:  alu_out = op_a | op_b;
            cpu_pkg::alu_xor: alu_out = op_a ^ op_b;
            cpu_pkg::alu_slt: alu_out = cpu_pkg::word_t'($signed(op_a) < $signed(op_b));
            default:          alu_out = '0;
        endcase
    end

    assign link_pc = id_ex.pc + cpu_pkg::word_t'(4);
    // JALR target comes out of the ALU add, bit 0 cleared
    assign target  = id_ex.ctrl.jump_reg ? {alu_out[$bits(alu_out)-1:1], 1'b0}
                                         : id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem.ctrl       = id_ex.ctrl;
        ex_mem.alu_result = id_ex.ctrl.jump ? link_pc : alu_out;
        ex_mem.store_data = rs2_fwd;
        ex_mem.target     = target;
        ex_mem.take       = id_ex.ctrl.jump || (id_ex.ctrl.branch && op_a == rs2_fwd);
        ex_mem.rd         = id_ex.rd;
    end

endmodule

// ==== rtl/memory/mem_stage.sv ====
// Memory stage
// Word data memory, redirect decision and writeback value select
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::ex_mem_t  ex_mem,
    output cpu_pkg::mem_wb_t  mem_wb,
    output logic              redirect,     // Taken branch or jump
    output cpu_pkg::word_t    redirect_pc,
    output cpu_pkg::word_t    data_mem0
);

    localparam int aw = $clog2(`DMEM_DEPTH);

    cpu_pkg::word_t dmem [`DMEM_DEPTH];
    logic [aw-1:0]  word_addr;              // Byte address modulo depth
    cpu_pkg::word_t load_data;

    assign word_addr = ex_mem.alu_result[aw+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.ctrl.mem_write) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    assign redirect    = ex_mem.take;
    assign redirect_pc = ex_mem.target;
    assign data_mem0   = dmem[0];

    assign mem_wb.reg_write = ex_mem.ctrl.reg_write;
    assign mem_wb.rd        = ex_mem.rd;
    assign mem_wb.wb_data   = ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write))
        else $error("load and store decoded together");

endmodule

// ==== rtl/riscv_pipeline_cpu.sv ====
// RISC-V five-stage pipeline, reduced RV32I
// IF, ID, EX, MEM, WB with forwarding, redirect resolved in MEM
// Instruction memory programmed through prog while enable is low
`timescale 1ns/1ps

module riscv_pipeline_cpu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  cpu_pkg::imem_write_t prog,
    output cpu_pkg::wb_trace_t   trace,
    output cpu_pkg::word_t       data_mem0
);

    cpu_pkg::word_t    if_instr;
    cpu_pkg::word_t    if_pc;
    cpu_pkg::if_id_t   if_id_d;
    cpu_pkg::if_id_t   if_id_q;
    cpu_pkg::ctrl_t    id_ctrl;
    cpu_pkg::word_t    id_imm;
    cpu_pkg::reg_idx_t id_rs1;
    cpu_pkg::reg_idx_t id_rs2;
    cpu_pkg::reg_idx_t id_rd;
    cpu_pkg::word_t    rf_rdata1;
    cpu_pkg::word_t    rf_rdata2;
    cpu_pkg::id_ex_t   id_ex_d;
    cpu_pkg::id_ex_t   id_ex_q;
    cpu_pkg::ex_mem_t  ex_mem_d;
    cpu_pkg::ex_mem_t  ex_mem_q;
    cpu_pkg::mem_wb_t  mem_wb_d;
    cpu_pkg::mem_wb_t  mem_wb_q;
    logic              redirect;    // Also the flush of the three younger slots
    cpu_pkg::word_t    redirect_pc;

    // ========================================
    // IF
    // ========================================
    fetch_stage u_fetch (.clk, .reset, .enable, .prog, .redirect, .redirect_pc,
                         .instr(if_instr), .pc(if_pc));
    assign if_id_d = '{instr: if_instr, pc: if_pc};
    pipe_reg #(.payload_t(cpu_pkg::if_id_t)) u_if_id (.clk, .reset, .flush(redirect),
                                                       .d(if_id_d), .q(if_id_q));

    // ========================================
    // ID, decoder and register file side by side
    // ========================================
    decoder u_dec (.instr(if_id_q.instr), .ctrl(id_ctrl), .imm(id_imm),
                   .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd));
    reg_file u_rf (.clk, .reset, .rs1(id_rs1), .rs2(id_rs2), .we(mem_wb_q.reg_write),
                   .wr(mem_wb_q.rd), .wdata(mem_wb_q.wb_data),
                   .rdata1(rf_rdata1), .rdata2(rf_rdata2));
    assign id_ex_d = '{ctrl: id_ctrl, pc: if_id_q.pc, rs1_data: rf_rdata1,
                       rs2_data: rf_rdata2, imm: id_imm, rs1: id_rs1, rs2: id_rs2, rd: id_rd};
    pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) u_id_ex (.clk, .reset, .flush(redirect),
                                                       .d(id_ex_d), .q(id_ex_q));

    // ========================================
    // EX, MEM, WB
    // ========================================
    execute_stage u_ex (.id_ex(id_ex_q),
                        .fwd_mem_data(ex_mem_q.alu_result), .fwd_mem_rd(ex_mem_q.rd),
                        .fwd_mem_we(ex_mem_q.ctrl.reg_write),
                        .fwd_wb_data(mem_wb_q.wb_data), .fwd_wb_rd(mem_wb_q.rd),
                        .fwd_wb_we(mem_wb_q.reg_write), .ex_mem(ex_mem_d));
    pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) u_ex_mem (.clk, .reset, .flush(redirect),
                                                         .d(ex_mem_d), .q(ex_mem_q));
    mem_stage u_mem (.clk, .reset, .ex_mem(ex_mem_q), .mem_wb(mem_wb_d), .redirect,
                     .redirect_pc, .data_mem0);
    // The redirecting jump itself still retires its link value
    pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) u_mem_wb (.clk, .reset, .flush(1'b0),
                                                         .d(mem_wb_d), .q(mem_wb_q));

    assign trace = '{valid: mem_wb_q.reg_write, rd: mem_wb_q.rd, data: mem_wb_q.wb_data};

endmodule

// ==== sim/tb_riscv_pipeline_cpu.sv ====
// Testbench for the five-stage RISC-V pipeline
// Small programs with their expected retire order and data word 0
// Each test resets the core, loads through prog, then runs with enable high
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_riscv_pipeline_cpu;

    localparam int n_tests      = 5;
    localparam int max_words    = 16;
    localparam int max_wb       = 16;
    localparam int reset_cycles = 16;
    localparam int budget       = 80;     // Cycles allowed after enable
    localparam int drain_cycles = 8;      // Extra writebacks show up here
    localparam int test_cycles  = reset_cycles + max_words + budget + 2;

    logic                 clk;
    logic                 reset;
    logic                 enable;
    cpu_pkg::imem_write_t prog;
    cpu_pkg::wb_trace_t   trace;
    logic [31:0]          data_mem0;

    // Test table
    string       test_name [n_tests];
    logic [31:0] prog_tab  [n_tests][max_words];
    int          prog_len  [n_tests];
    logic [4:0]  exp_rd    [n_tests][max_wb];
    logic [31:0] exp_data  [n_tests][max_wb];
    int          exp_cnt   [n_tests];
    logic [31:0] exp_mem0  [n_tests];
    int          n_pass;
    int          n_fail;

    riscv_pipeline_cpu DUT (.clk, .reset, .enable, .prog, .trace, .data_mem0);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    // Watchdog sized from the per-test budgets
    initial begin
        #((n_tests * test_cycles + 100) * 10);
        $display("watchdog expired, the run did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    // ========================================
    // RV32I encoders
    // ========================================
    function automatic logic [31:0] rtype_word(int sub, int f3, int rd, int rs1, int rs2);
        return {(sub != 0) ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), `OP_RTYPE};
    endfunction

    // ADDI, LW and JALR share the I layout
    function automatic logic [31:0] itype_word(logic [6:0] op, int f3, int rd, int rs1,
                                               int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] store_word(int rs2, int rs1, int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] branch_word(int rs1, int rs2, int imm);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'b000, v[4:1], v[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(int rd, int imm);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), `OP_JAL};
    endfunction

    // Instruction with no writeback (store, branch, flushed slot)
    task automatic silent(input int t, input logic [31:0] w);
        prog_tab[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    // Instruction plus the writeback it must retire
    task automatic writes(input int t, input logic [31:0] w, input int rd,
                          input logic [31:0] v);
        silent(t, w);
        exp_rd[t][exp_cnt[t]]   = 5'(rd);
        exp_data[t][exp_cnt[t]] = v;
        exp_cnt[t]++;
    endtask

    // ========================================
    // Programs and expected results
    // ========================================
    task automatic build_tests();
        logic [31:0] halt;
        halt = jal_word(0, 0);    // jal x0, 0 spins without retiring
        for (int t = 0; t < n_tests; t++) begin
            exp_mem0[t] = '0;
        end
        test_name[0] = "alu";
        writes(0, itype_word(`OP_ITYPE, 0, 2, 0, -7), 2, -7);
        writes(0, itype_word(`OP_ITYPE, 0, 3, 0, 12), 3, 12);
        writes(0, itype_word(`OP_ITYPE, 0, 4, 0, 2047), 4, 2047);
        writes(0, itype_word(`OP_ITYPE, 0, 6, 0, -1), 6, -1);
        writes(0, rtype_word(0, 0, 5, 2, 3), 5, -7 + 12);       // add
        writes(0, rtype_word(1, 0, 7, 2, 3), 7, -7 - 12);       // sub
        writes(0, rtype_word(0, 7, 8, 3, 4), 8, 12 & 2047);     // and
        writes(0, rtype_word(0, 6, 9, 2, 3), 9, -7 | 12);       // or
        writes(0, rtype_word(0, 4, 10, 6, 4), 10, -1 ^ 2047);   // xor
        writes(0, rtype_word(0, 2, 11, 2, 3), 11, 32'(-7 < 12));
        writes(0, rtype_word(0, 2, 12, 3, 2), 12, 32'(12 < -7));
        silent(0, halt);
        test_name[1] = "forwarding";
        writes(1, rtype_word(0, 0, 5, 2, 3), 5, 0);             // x2 and x3 cleared by reset
        writes(1, itype_word(`OP_ITYPE, 0, 1, 0, 3), 1, 3);
        writes(1, itype_word(`OP_ITYPE, 0, 1, 1, 4), 1, 3 + 4);  // Distance 1
        writes(1, rtype_word(0, 0, 2, 1, 1), 2, 7 + 7);
        writes(1, rtype_word(1, 0, 3, 2, 1), 3, 14 - 7);        // Distances 1 and 2
        silent(1, itype_word(`OP_ITYPE, 0, 0, 3, 100));         // x0 write dropped
        writes(1, rtype_word(0, 0, 4, 0, 3), 4, 0 + 7);
        silent(1, halt);
        test_name[2] = "memory";
        writes(2, itype_word(`OP_ITYPE, 0, 1, 0, 'h55), 1, 'h55);
        silent(2, store_word(1, 0, 0));                         // Forwarded store data
        writes(2, itype_word(`OP_ITYPE, 0, 2, 1, 1), 2, 'h55 + 1);
        writes(2, itype_word(`OP_LOAD, 2, 3, 0, 0), 3, 'h55);
        writes(2, itype_word(`OP_ITYPE, 0, 4, 0, 1), 4, 1);     // Load delay slot
        writes(2, rtype_word(0, 0, 5, 3, 4), 5, 'h55 + 1);
        writes(2, rtype_word(0, 0, 6, 5, 5), 6, 2 * ('h55 + 1));
        silent(2, store_word(6, 0, 0));
        silent(2, halt);
        exp_mem0[2] = 32'(2 * ('h55 + 1));
        test_name[3] = "branch";
        writes(3, itype_word(`OP_ITYPE, 0, 1, 0, 5), 1, 5);
        writes(3, itype_word(`OP_ITYPE, 0, 2, 0, 5), 2, 5);
        writes(3, itype_word(`OP_ITYPE, 0, 3, 0, 6), 3, 6);
        silent(3, branch_word(1, 3, 8));                        // 5 != 6, falls through
        writes(3, itype_word(`OP_ITYPE, 0, 4, 0, 1), 4, 1);
        silent(3, branch_word(1, 2, 16));                       // Taken to word 9
        silent(3, itype_word(`OP_ITYPE, 0, 5, 0, 1));
        silent(3, itype_word(`OP_ITYPE, 0, 6, 0, 1));
        silent(3, itype_word(`OP_ITYPE, 0, 7, 0, 1));
        writes(3, itype_word(`OP_ITYPE, 0, 8, 0, 2), 8, 2);
        silent(3, halt);
        test_name[4] = "jump";
        writes(4, jal_word(1, 12), 1, 0 + 4);                   // Link is PC+4
        silent(4, itype_word(`OP_ITYPE, 0, 5, 0, 1));
        silent(4, itype_word(`OP_ITYPE, 0, 6, 0, 1));
        writes(4, itype_word(`OP_ITYPE, 0, 2, 0, 28), 2, 28);
        writes(4, itype_word(`OP_JALR, 0, 3, 2, 4), 3, 16 + 4); // To 28 + 4
        silent(4, itype_word(`OP_ITYPE, 0, 7, 0, 1));
        silent(4, itype_word(`OP_ITYPE, 0, 8, 0, 1));
        silent(4, itype_word(`OP_ITYPE, 0, 9, 0, 1));
        writes(4, itype_word(`OP_ITYPE, 0, 4, 1, 0), 4, 4);
        silent(4, halt);
    endtask

    // ========================================
    // One test does reset, load, run and check
    // ========================================
    task automatic run_test(input int t);
        int beats;
        int errs;
        int cyc;
        int settle;
        beats  = 0;
        errs   = 0;
        cyc    = 0;
        settle = 0;
        enable = 1'b0;
        reset  = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < prog_len[t]; k++) begin
            prog.we   = 1'b1;
            prog.addr = 7'(k);
            prog.data = prog_tab[t][k];
            @(negedge clk);
            assert (!trace.valid) else begin     // Core is held
                $display("test %0d: writeback seen before enable rose", t);
                errs++;
            end
        end
        prog.we = 1'b0;
        enable  = 1'b1;
        while (cyc < budget && settle < drain_cycles) begin
            @(negedge clk);
            cyc++;
            if (beats >= exp_cnt[t]) settle++;
            if (trace.valid) begin
                assert (beats < exp_cnt[t]) else begin
                    $display("test %0d: unexpected extra writeback to x%0d", t, trace.rd);
                    errs++;
                end
                if (beats < exp_cnt[t]) begin
                    assert (trace.rd == exp_rd[t][beats]) else begin
                        $display("FAIL trace.rd test %0d beat %0d: got %h expected %h",
                                 t, beats, trace.rd, exp_rd[t][beats]);
                        errs++;
                    end
                    assert (trace.data == exp_data[t][beats]) else begin
                        $display("FAIL trace.data test %0d beat %0d: got %h expected %h",
                                 t, beats, trace.data, exp_data[t][beats]);
                        errs++;
                    end
                end
                beats++;
            end
        end
        assert (beats >= exp_cnt[t]) else begin
            $display("test %0d: only %0d of %0d writebacks arrived in time",
                     t, beats, exp_cnt[t]);
            errs++;
        end
        assert (data_mem0 == exp_mem0[t]) else begin
            $display("FAIL data_mem0 test %0d: got %h expected %h", t, data_mem0, exp_mem0[t]);
            errs++;
        end
        enable = 1'b0;                           // Pipe drains before the next reset
        if (errs == 0) begin
            $display("test %0d %s: ok, %0d writebacks", t, test_name[t], beats);
            n_pass++;
        end else begin
            $display("test %0d %s: %0d errors", t, test_name[t], errs);
            n_fail++;
        end
    endtask

    initial begin
        reset  = 1'b1;
        enable = 1'b0;
        prog   = '0;
        n_pass = 0;
        n_fail = 0;
        build_tests();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed", n_tests, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+common
common/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/fetch/fetch_stage.sv
rtl/decode/decoder.sv
rtl/decode/reg_file.sv
rtl/execute/execute_stage.sv
rtl/memory/mem_stage.sv
rtl/riscv_pipeline_cpu.sv
sim/tb_riscv_pipeline_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build the pipeline testbench with Verilator, run it, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module tb_riscv_pipeline_cpu -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run.sh: failures reported, see sim.log"
    exit 1
fi
exit 0
